//--- source/loadBufferPkg.sv
package loadBufferPkg;

    // All sequence numbers share this width and wrap around
    localparam int SQN_WIDTH = 7;

    typedef logic [SQN_WIDTH-1:0] sqN_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } memSize_e;

    // An entry waits only while it holds an MMIO load that has not gone out yet
    typedef enum logic [1:0] {
        ENTRY_FREE    = 2'd0,
        ENTRY_WAITING = 2'd1,
        ENTRY_ISSUED  = 2'd2
    } entryState_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        memSize_e    size;
        sqN_t        sqN;
        sqN_t        loadSqN;
        logic        isMmio;
    } loadOp_t;

    // Top nibble of the address that selects the memory-mapped I/O region
    localparam logic [3:0] MMIO_REGION = 4'hF;

    // Wrap-aware age compare, true when a comes before b in program order
    function automatic logic isOlder(sqN_t a, sqN_t b);
        sqN_t diff;
        diff = a - b;
        return diff[SQN_WIDTH-1];
    endfunction

endpackage

//--- source/memOpIf.sv
`timescale 1ns/100ps

interface memOpIf import loadBufferPkg::*; ();

    logic        valid;
    logic        isLoad;
    logic        isStore;
    logic [31:0] addr;
    memSize_e    size;
    sqN_t        sqN;
    sqN_t        loadSqN;
    logic        isMmio;

    // The classifier drives one operation per cycle and the table takes it unconditionally
    modport source (
        output valid, isLoad, isStore, addr, size, sqN, loadSqN, isMmio
    );

    modport sink (
        input valid, isLoad, isStore, addr, size, sqN, loadSqN, isMmio
    );

endinterface

//--- source/opClassifier.sv
`timescale 1ns/100ps

module opClassifier import loadBufferPkg::*; (
    input  logic        opValid,
    input  logic        opIsLoad,
    input  logic        opIsStore,
    input  logic [31:0] opAddr,
    input  memSize_e    opSize,
    input  sqN_t        opSqN,
    input  sqN_t        opLoadSqN,
    input  logic        branchTaken,
    input  sqN_t        branchSqN,
    output loadOp_t     fastLoad,
    memOpIf.source      op
);

    logic isMmio;
    logic squashed;

    assign isMmio = opAddr[31:28] == MMIO_REGION;

    // An operation younger than a taken branch is on the wrong path
    assign squashed = branchTaken && isOlder(branchSqN, opSqN);

    // Ordinary loads go straight on to the memory pipeline
    always_comb begin
        fastLoad.valid = opValid && opIsLoad && !isMmio;
        fastLoad.addr = opAddr;
        fastLoad.size = opSize;
        fastLoad.sqN = opSqN;
        fastLoad.loadSqN = opLoadSqN;
        fastLoad.isMmio = isMmio;
    end

    // Every surviving operation goes to the entry table, loads for
    // tracking and stores for the ordering check
    assign op.valid = opValid && !squashed;
    assign op.isLoad = opIsLoad;
    assign op.isStore = opIsStore;
    assign op.addr = opAddr;
    assign op.size = opSize;
    assign op.sqN = opSqN;
    assign op.loadSqN = opLoadSqN;
    assign op.isMmio = isMmio;

endmodule

//--- source/entryTable.sv
`timescale 1ns/100ps

module entryTable import loadBufferPkg::*; #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic    clk,
    input  logic    rst,
    memOpIf.sink    op,
    input  sqN_t    comLoadSqN,
    input  sqN_t    comSqN,
    input  logic    sqDone,
    input  logic    branchTaken,
    input  sqN_t    branchLoadSqN,
    input  logic    branchFlush,
    input  logic    issueTake,
    output logic    issueReq,
    output loadOp_t issueOp,
    output logic    conflict,
    output sqN_t    conflictSqN,
    output sqN_t    conflictLoadSqN
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);
    localparam int TAG_W = SQN_WIDTH - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;

    // The entry index is the low part of loadSqN, so only the high part is kept
    logic [31:0]      entAddr  [NUM_ENTRIES];
    memSize_e         entSize  [NUM_ENTRIES];
    sqN_t             entSqN   [NUM_ENTRIES];
    logic [TAG_W-1:0] entHigh  [NUM_ENTRIES];
    entryState_e      entState [NUM_ENTRIES];

    sqN_t lastComLoadSqN;
    sqN_t branchDelta;
    idx_t curIdx;
    idx_t lastIdx;
    idx_t insIdx;
    idx_t commitStep;
    idx_t branchDist;
    logic branchInWindow;

    logic [NUM_ENTRIES-1:0] commitMask;
    logic [NUM_ENTRIES-1:0] branchMask;
    logic [NUM_ENTRIES-1:0] overlapMask;

    assign curIdx = comLoadSqN[IDX_W-1:0];
    assign lastIdx = lastComLoadSqN[IDX_W-1:0];
    assign insIdx = op.loadSqN[IDX_W-1:0];
    assign commitStep = curIdx - lastIdx;

    // Distance of the branch point from the commit pointer, which must lie in the window
    assign branchDelta = branchLoadSqN - comLoadSqN;
    assign branchInWindow = branchDelta < sqN_t'(NUM_ENTRIES);
    assign branchDist = branchDelta[IDX_W-1:0];

    // Commit frees what lies between last cycle's pointer and this one.
    // A branch frees everything from its load onward, up to the commit pointer
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            commitMask[i] = idx_t'(idx_t'(i) - lastIdx) < commitStep;
            branchMask[i] = branchTaken && (branchFlush ||
                (branchInWindow && idx_t'(idx_t'(i) - curIdx) >= branchDist));
        end
    end

    // Memory-order check of the incoming store against issued younger loads
    always_comb begin
        sqN_t entLoadSqN;
        logic wordHit;
        logic byteHit;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entLoadSqN = {entHigh[i], idx_t'(i)};
            wordHit = entAddr[i][31:2] == op.addr[31:2];
            case (op.size)
                SIZE_WORD: byteHit = 1'b1;
                SIZE_HALF: byteHit = entSize[i] == SIZE_WORD || entAddr[i][1] == op.addr[1];
                default:   byteHit = entSize[i] != SIZE_BYTE ||
                                     entAddr[i][1:0] == op.addr[1:0];
            endcase
            overlapMask[i] = entState[i] == ENTRY_ISSUED && wordHit && byteHit &&
                             !isOlder(entLoadSqN, op.loadSqN);
        end
    end

    // The rollback restarts right after the store, so it carries the store's numbers
    assign conflict = op.valid && op.isStore && (|overlapMask);
    assign conflictSqN = op.sqN;
    assign conflictLoadSqN = op.loadSqN;

    // MMIO loads leave in program order, only from the head of the table
    // and only once every older store has drained
    always_comb begin
        issueReq = entState[curIdx] == ENTRY_WAITING && entSqN[curIdx] == comSqN && sqDone;
        issueOp.valid = issueReq;
        issueOp.addr = entAddr[curIdx];
        issueOp.size = entSize[curIdx];
        issueOp.sqN = entSqN[curIdx];
        issueOp.loadSqN = {entHigh[curIdx], curIdx};
        issueOp.isMmio = entAddr[curIdx][31:28] == MMIO_REGION;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entState[i] <= ENTRY_FREE;
            end
            lastComLoadSqN <= '0;
        end else begin
            lastComLoadSqN <= comLoadSqN;

            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (commitMask[i] || branchMask[i]) begin
                    entState[i] <= ENTRY_FREE;
                end
            end

            if (issueReq && issueTake) begin
                entState[curIdx] <= ENTRY_ISSUED;
            end

            // A new load lands last so it wins over a stale free of its slot
            if (op.valid && op.isLoad) begin
                entState[insIdx] <= op.isMmio ? ENTRY_WAITING : ENTRY_ISSUED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid && op.isLoad) begin
            entAddr[insIdx] <= op.addr;
            entSize[insIdx] <= op.size;
            entSqN[insIdx] <= op.sqN;
            entHigh[insIdx] <= op.loadSqN[SQN_WIDTH-1:IDX_W];
        end
    end

endmodule

//--- source/lateIssue.sv
`timescale 1ns/100ps

module lateIssue import loadBufferPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issueReq,
    input  loadOp_t issueOp,
    input  logic    stall,
    input  logic    branchTaken,
    input  sqN_t    branchSqN,
    input  logic    branchFlush,
    output logic    issueTake,
    output loadOp_t lateLoad
);

    logic squashHeld;

    // Flush drops anything, otherwise only a load on the wrong path goes
    assign squashHeld = branchFlush || isOlder(branchSqN, lateLoad.sqN);

    // A new load fits when the slot is empty or its load leaves this cycle.
    // Nothing is taken during a branch, the waiting entry just stays put
    assign issueTake = (!lateLoad.valid || !stall) && !branchTaken;

    always_ff @(posedge clk) begin
        if (rst) begin
            lateLoad.valid <= 1'b0;
        end else begin
            // Without stall the memory pipeline consumes the held load
            if (!stall) begin
                lateLoad.valid <= 1'b0;
            end

            if (branchTaken) begin
                if (squashHeld) begin
                    lateLoad.valid <= 1'b0;
                end
            end else if (issueTake && issueReq) begin
                lateLoad <= issueOp;
            end
        end
    end

endmodule

//--- source/loadBuffer.sv
`timescale 1ns/100ps

module loadBuffer import loadBufferPkg::*; #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        opValid,
    input  logic        opIsLoad,
    input  logic        opIsStore,
    input  logic [31:0] opAddr,
    input  memSize_e    opSize,
    input  sqN_t        opSqN,
    input  sqN_t        opLoadSqN,

    input  sqN_t        comLoadSqN,
    input  sqN_t        comSqN,
    input  logic        sqDone,

    input  logic        branchTaken,
    input  sqN_t        branchSqN,
    input  sqN_t        branchLoadSqN,
    input  logic        branchFlush,

    input  logic        stall,

    output loadOp_t     fastLoad,
    output loadOp_t     lateLoad,
    output logic        rollbackValid,
    output sqN_t        rollbackSqN,
    output sqN_t        rollbackLoadSqN,
    output sqN_t        maxLoadSqN
);

    logic    issueReq;
    logic    issueTake;
    loadOp_t issueOp;

    memOpIf opBus ();

    opClassifier i_opClassifier (
        .opValid     (opValid),
        .opIsLoad    (opIsLoad),
        .opIsStore   (opIsStore),
        .opAddr      (opAddr),
        .opSize      (opSize),
        .opSqN       (opSqN),
        .opLoadSqN   (opLoadSqN),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .fastLoad    (fastLoad),
        .op          (opBus.source)
    );

    entryTable #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_entryTable (
        .clk             (clk),
        .rst             (rst),
        .op              (opBus.sink),
        .comLoadSqN      (comLoadSqN),
        .comSqN          (comSqN),
        .sqDone          (sqDone),
        .branchTaken     (branchTaken),
        .branchLoadSqN   (branchLoadSqN),
        .branchFlush     (branchFlush),
        .issueTake       (issueTake),
        .issueReq        (issueReq),
        .issueOp         (issueOp),
        .conflict        (rollbackValid),
        .conflictSqN     (rollbackSqN),
        .conflictLoadSqN (rollbackLoadSqN)
    );

    lateIssue i_lateIssue (
        .clk         (clk),
        .rst         (rst),
        .issueReq    (issueReq),
        .issueOp     (issueOp),
        .stall       (stall),
        .branchTaken (branchTaken),
        .branchSqN   (branchSqN),
        .branchFlush (branchFlush),
        .issueTake   (issueTake),
        .lateLoad    (lateLoad)
    );

    // Upstream may send loads up to the last slot ahead of the commit pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            maxLoadSqN <= sqN_t'(NUM_ENTRIES - 1);
        end else begin
            maxLoadSqN <= comLoadSqN + sqN_t'(NUM_ENTRIES - 1);
        end
    end

endmodule

//--- test/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int HALF_PERIOD = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // Reset drops on a rising edge so the first free cycle starts clean
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- test/loadBufferTb.sv
`timescale 1ns/100ps

module loadBufferTb import loadBufferPkg::*; ();

    localparam int NUM_COLS = 26;
    localparam int MAX_ROWS = 64;
    localparam string VECTOR_FILE = "test/loadBufferVectors.txt";

    logic        clk;
    logic        rst;
    logic        opValid;
    logic        opIsLoad;
    logic        opIsStore;
    logic [31:0] opAddr;
    memSize_e    opSize;
    sqN_t        opSqN;
    sqN_t        opLoadSqN;
    sqN_t        comLoadSqN;
    sqN_t        comSqN;
    logic        sqDone;
    logic        branchTaken;
    sqN_t        branchSqN;
    sqN_t        branchLoadSqN;
    logic        branchFlush;
    logic        stall;
    loadOp_t     fastLoad;
    loadOp_t     lateLoad;
    logic        rollbackValid;
    sqN_t        rollbackSqN;
    sqN_t        rollbackLoadSqN;
    sqN_t        maxLoadSqN;

    logic [31:0] vec [MAX_ROWS][NUM_COLS];
    int numRows = 0;
    int rowIdx = 0;
    int errorCount = 0;
    int checkCount = 0;
    logic vectorsRead = 1'b0;

    clockGen i_clockGen (
        .clk (clk),
        .rst (rst)
    );

    loadBuffer #(
        .NUM_ENTRIES (8)
    ) i_dut (.*);

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s vector %0d: expected %h, actual %h",
                     name, rowIdx, expected, actual);
        end
    endtask

    // Lines that start with a hash are column notes and carry no vector
    task automatic storeLine(input string line);
        logic [31:0] f [NUM_COLS];
        int cnt;
        if (line.len() > 0 && line.getc(0) != "#") begin
            cnt = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                f[22], f[23], f[24], f[25]);
            if (cnt == NUM_COLS) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    vec[numRows][c] = f[c];
                end
                numRows++;
            end else if (cnt > 0) begin
                $display("A vector line could not be parsed: %s", line);
                errorCount++;
            end
        end
    endtask

    // The late load carries the fields of the earlier load with the same sqN
    function automatic int findLoadRow(input int r, input logic [31:0] sqN);
        int found;
        found = -1;
        for (int k = 0; k < r; k++) begin
            if (vec[k][0][0] && vec[k][1][0] && vec[k][5] == sqN) begin
                found = k;
            end
        end
        return found;
    endfunction

    task automatic driveRow(input int r);
        opValid <= vec[r][0][0];
        opIsLoad <= vec[r][1][0];
        opIsStore <= vec[r][2][0];
        // An idle row leaves the address open, so it gets random bits
        opAddr <= vec[r][0][0] ? vec[r][3] : $urandom();
        opSize <= memSize_e'(vec[r][4][1:0]);
        opSqN <= vec[r][5][SQN_WIDTH-1:0];
        opLoadSqN <= vec[r][6][SQN_WIDTH-1:0];
        comLoadSqN <= vec[r][7][SQN_WIDTH-1:0];
        comSqN <= vec[r][8][SQN_WIDTH-1:0];
        sqDone <= vec[r][9][0];
        branchTaken <= vec[r][10][0];
        branchSqN <= vec[r][11][SQN_WIDTH-1:0];
        branchLoadSqN <= vec[r][12][SQN_WIDTH-1:0];
        branchFlush <= vec[r][13][0];
        stall <= vec[r][14][0];
    endtask

    // Mask bits select fast load, late load, rollback and maxLoadSqN.
    // Payload fields only matter while the expected valid is set
    task automatic compareRow(input int r);
        logic [3:0] mask;
        int src;
        mask = vec[r][25][3:0];
        if (mask[0]) begin
            checkValue("fastLoad.valid", vec[r][15], 32'(fastLoad.valid));
            if (vec[r][15][0]) begin
                checkValue("fastLoad.addr", vec[r][16], fastLoad.addr);
                checkValue("fastLoad.sqN", vec[r][17], 32'(fastLoad.sqN));
                checkValue("fastLoad.size", vec[r][4], 32'(fastLoad.size));
                checkValue("fastLoad.loadSqN", vec[r][6], 32'(fastLoad.loadSqN));
                checkValue("fastLoad.isMmio", 32'd0, 32'(fastLoad.isMmio));
            end
        end
        if (mask[1]) begin
            checkValue("lateLoad.valid", vec[r][18], 32'(lateLoad.valid));
            if (vec[r][18][0]) begin
                checkValue("lateLoad.addr", vec[r][19], lateLoad.addr);
                checkValue("lateLoad.sqN", vec[r][20], 32'(lateLoad.sqN));
                src = findLoadRow(r, vec[r][20]);
                if (src < 0) begin
                    $display("No earlier load matches the late load of vector %0d", r);
                    errorCount++;
                end else begin
                    checkValue("lateLoad.size", vec[src][4], 32'(lateLoad.size));
                    checkValue("lateLoad.loadSqN", vec[src][6], 32'(lateLoad.loadSqN));
                end
                // Only MMIO loads wait in the table for late issue
                checkValue("lateLoad.isMmio", 32'd1, 32'(lateLoad.isMmio));
            end
        end
        if (mask[2]) begin
            checkValue("rollbackValid", vec[r][21], 32'(rollbackValid));
            if (vec[r][21][0]) begin
                checkValue("rollbackSqN", vec[r][22], 32'(rollbackSqN));
                checkValue("rollbackLoadSqN", vec[r][23], 32'(rollbackLoadSqN));
            end
        end
        if (mask[3]) begin
            checkValue("maxLoadSqN", vec[r][24], 32'(maxLoadSqN));
        end
    endtask

    initial begin
        int fd;
        string line;
        opValid = 1'b0;
        opIsLoad = 1'b0;
        opIsStore = 1'b0;
        opAddr = '0;
        opSize = SIZE_BYTE;
        opSqN = '0;
        opLoadSqN = '0;
        comLoadSqN = '0;
        comSqN = '0;
        sqDone = 1'b0;
        branchTaken = 1'b0;
        branchSqN = '0;
        branchLoadSqN = '0;
        branchFlush = 1'b0;
        stall = 1'b0;
        void'($urandom(32'he17f));

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("The vector file %s could not be opened", VECTOR_FILE);
            errorCount++;
        end else begin
            while (!$feof(fd) && numRows < MAX_ROWS) begin
                line = "";
                void'($fgets(line, fd));
                storeLine(line);
            end
            $fclose(fd);
            if (numRows == 0) begin
                $display("The vector file holds no vectors");
                errorCount++;
            end
        end
        vectorsRead = 1'b1;

        // Reset has to be seen high before its release counts
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        for (int r = 0; r < numRows; r++) begin
            @(posedge clk);
            rowIdx = r;
            driveRow(r);
            @(negedge clk);
            compareRow(r);
        end

        @(posedge clk);
        $display("%0d errors in %0d checks over %0d vectors", errorCount, checkCount, numRows);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // One cycle per vector plus slack that covers reset and the closing cycle
    initial begin
        wait (vectorsRead);
        repeat (numRows + 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", numRows + 20);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- test/loadBufferVectors.txt
# In: opValid opIsLoad opIsStore opAddr opSize opSqN opLoadSqN comLoadSqN comSqN sqDone
#     branchTaken branchSqN branchLoadSqN branchFlush stall (opAddr is random on idle rows)
# Out: fastValid fastAddr fastSqN lateValid lateAddr lateSqN rbValid rbSqN rbLoadSqN maxLoadSqN
# Last column is the check mask: bit0 fast, bit1 late, bit2 rollback, bit3 maxLoadSqN
1 1 0 00001004 2 11 00  00 00 0  0 00 00 0  0   1 00001004 11  0 00000000 00  0 00 00  07  f
1 1 0 f0000010 2 12 01  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  07  f
1 1 0 f0000020 1 13 02  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  07  f
1 1 0 00002001 0 14 03  00 00 0  0 00 00 0  0   1 00002001 14  0 00000000 00  0 00 00  07  f
1 0 1 00001006 1 10 00  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  1 10 00  07  f
1 0 1 00002002 1 0e 00  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  07  f
1 0 1 00002001 0 0d 03  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  1 0d 03  07  f
1 0 1 00001004 2 15 04  00 00 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  07  f
0 0 0 00000000 0 00 00  01 12 1  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  07  f
1 0 1 00001004 2 0c 00  02 13 1  0 00 00 0  1   0 00000000 00  1 f0000010 12  0 00 00  08  f
0 0 0 00000000 0 00 00  02 13 1  0 00 00 0  1   0 00000000 00  1 f0000010 12  0 00 00  09  f
0 0 0 00000000 0 00 00  02 13 1  0 00 00 0  0   0 00000000 00  1 f0000010 12  0 00 00  09  f
0 0 0 00000000 0 00 00  02 13 0  0 00 00 0  0   0 00000000 00  1 f0000020 13  0 00 00  09  f
1 1 0 00003000 2 20 04  02 13 0  0 00 00 0  0   1 00003000 20  0 00000000 00  0 00 00  09  f
1 1 0 f0000030 2 21 05  02 13 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  09  f
1 0 1 00003002 1 1d 04  02 13 0  0 00 00 0  0   0 00000000 00  0 00000000 00  1 1d 04  09  f
0 0 0 00000000 0 00 00  02 13 0  1 1f 04 0  0   0 00000000 00  0 00000000 00  0 00 00  09  f
1 0 1 00003002 1 1d 04  02 13 0  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  09  f
0 0 0 00000000 0 00 00  05 21 1  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  09  f
0 0 0 00000000 0 00 00  05 21 1  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  0c  f
0 0 0 00000000 0 00 00  05 21 1  0 00 00 0  0   0 00000000 00  0 00000000 00  0 00 00  0c  f

//--- list.f
source/loadBufferPkg.sv
source/memOpIf.sv
source/opClassifier.sv
source/entryTable.sv
source/lateIssue.sv
source/loadBuffer.sv
test/clockGen.sv
test/loadBufferTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module loadBufferTb --Mdir obj_dir -o loadBufferSim

output=$(./obj_dir/loadBufferSim)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi
